//--- ks10Pkg.sv
// Processor-side definitions for the KS10 memory path
// Bit 0 is the most significant bit, as in PDP-10 documentation

package ks10Pkg;

   // Width of a PDP-10 data word
   localparam int wordWidth = 36;

   // Physical word address width
   // 20 bits reaches 1M words, the full KS10 address space
   localparam int addrWidth = 20;

   // One 36-bit data word
   // Left half is bits 0 to 17, right half bits 18 to 35
   typedef logic [0:wordWidth-1] wordT;

   // Physical word address as seen by the requester
   typedef logic [0:addrWidth-1] addrT;

endpackage

//--- ssramPkg.sv
// SSRAM device and memory configuration definitions

package ssramPkg;

   // Address pins on the SSRAM device
   localparam int ssramAddrWidth = 23;

   // Size field width, enough to hold 0 to 32 units
   localparam int unitsWidth = 6;

   // Memory is sized in 32K-word units
   // Address bits above this shift select the unit
   localparam int unitShift = 15;

   // SSRAM address pin vector
   // Processor address sits in the low 20 bits
   typedef logic [0:ssramAddrWidth-1] ssramAddrT;

   // Memory size in units
   typedef logic [0:unitsWidth-1] unitsT;

   // Largest size that fits the 20-bit address space
   localparam unitsT maxUnits = 6'd32;

endpackage

//--- memConfig.sv
`timescale 1ns/10ps

// Memory configuration register block
// Holds the populated memory size and the write-protect bit

module memConfig
  #(
    // Size after reset, in 32K-word units
    parameter ssramPkg::unitsT defaultUnits = 1
   )
  (
   input  logic            clk,
   input  logic            reset,
   // Configuration strobe, one cycle
   input  logic            cfgWrite,
   // Requested size in units
   input  ssramPkg::unitsT cfgUnits,
   // Requested write-protect state
   input  logic            cfgProtect,
   // Current size seen by the controller
   output ssramPkg::unitsT memUnits,
   // Current write-protect state
   output logic            writeProtect
  );

   // Size after clamping to the address space limit
   ssramPkg::unitsT clampedUnits;

   //
   // Clamp the requested size
   // Anything above 32 units would exceed 1M words
   //

   always_comb
   begin
      if (cfgUnits > ssramPkg::maxUnits)
      begin
         clampedUnits = ssramPkg::maxUnits;
      end
      else
      begin
         clampedUnits = cfgUnits;
      end
   end

   //
   // Configuration registers
   // Both fields load together on the strobe
   // New values steer strobes sampled from the next edge on
   //

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         // Board default size, writes allowed
         memUnits     <= defaultUnits;
         writeProtect <= 1'b0;
      end
      else if (cfgWrite)
      begin
         memUnits     <= clampedUnits;
         writeProtect <= cfgProtect;
      end
   end

endmodule

//--- memCtrl.sv
`timescale 1ns/10ps

// Main memory controller
// Checks each request, then runs one flow-through SSRAM cycle
// Faults are answered in the cycle after the strobe

module memCtrl
  (
   input  logic               clk,
   input  logic               reset,
   // Requester strobes, one cycle each
   input  logic               memRead,
   input  logic               memWrite,
   input  ks10Pkg::addrT      memAddr,
   input  ks10Pkg::wordT      memWriteData,
   // Configuration from memConfig
   input  ssramPkg::unitsT    memUnits,
   input  logic               writeProtect,
   // Responses to the requester
   output ks10Pkg::wordT      memReadData,
   output logic               memAck,
   output logic               memNxm,
   output logic               memProt,
   output logic               memBusy,
   // SSRAM pins
   output ssramPkg::ssramAddrT ssramAddr,
   inout  ks10Pkg::wordT      ssramData,
   output logic               ssramWr
  );

   // Sequencer states
   typedef enum logic [1:0]
   {
      stateIdle,
      stateWrite,
      stateRead
   } stateT;

   stateT state;

   // Word held on the bus for the write cycle
   ks10Pkg::wordT writeData;

   // Unit number of the requested address
   ks10Pkg::addrT addrUnit;

   // Configured size widened to compare against addrUnit
   ks10Pkg::addrT unitLimit;

   // Request decisions
   logic inRange;
   logic accept;
   logic startNxm;
   logic startProt;
   logic startWrite;
   logic startRead;

   //
   // Request checks
   // Strobes are only taken while idle, so a busy strobe is dropped
   // Write has priority if both strobes show up together
   //

   assign addrUnit  = memAddr >> ssramPkg::unitShift;
   assign unitLimit = ks10Pkg::addrT'(memUnits);
   assign inRange   = addrUnit < unitLimit;

   assign accept     = (state == stateIdle) & (memRead | memWrite);
   // Out of range wins over protection
   assign startNxm   = accept & ~inRange;
   assign startProt  = accept & inRange & memWrite & writeProtect;
   assign startWrite = accept & inRange & memWrite & ~writeProtect;
   assign startRead  = accept & inRange & ~memWrite;

   //
   // Sequencer and response registers
   //

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state       <= stateIdle;
         ssramWr     <= 1'b0;
         memAck      <= 1'b0;
         memNxm      <= 1'b0;
         memProt     <= 1'b0;
         memReadData <= '0;
      end
      else
      begin
         // Fault pulses need no SSRAM cycle
         memNxm  <= startNxm;
         memProt <= startProt;
         memAck  <= 1'b0;
         case (state)
            stateIdle:
            begin
               if (startWrite)
               begin
                  // Write enable goes out with address and data
                  state   <= stateWrite;
                  ssramWr <= 1'b1;
               end
               else if (startRead)
               begin
                  state <= stateRead;
               end
            end
            stateWrite:
            begin
               // SSRAM took the word on the falling edge
               state   <= stateIdle;
               ssramWr <= 1'b0;
               memAck  <= 1'b1;
            end
            stateRead:
            begin
               // Flow-through data is on the bus by now
               state       <= stateIdle;
               memReadData <= ssramData;
               memAck      <= 1'b1;
            end
            default:
            begin
               state   <= stateIdle;
               ssramWr <= 1'b0;
            end
         endcase
      end
   end

   //
   // SSRAM address and write data
   // Loaded when a cycle starts
   //

   always_ff @(posedge clk)
   begin
      if (startWrite | startRead)
      begin
         // Upper address pins are zero
         ssramAddr <= ssramPkg::ssramAddrT'(memAddr);
      end
      if (startWrite)
      begin
         writeData <= memWriteData;
      end
   end

   // Busy for the whole SSRAM cycle
   assign memBusy = (state != stateIdle);

   // Bus driven only while writing, the SSRAM owns it otherwise
   assign ssramData = (state == stateWrite) ? writeData : 'z;

endmodule

//--- ks10Mem.sv
`timescale 1ns/10ps

// KS10 main memory path
// Configuration registers plus the SSRAM controller

module ks10Mem
  #(
    // Populated size after reset, in 32K-word units
    parameter ssramPkg::unitsT defaultUnits = 1
   )
  (
   input  logic               clk,
   input  logic               reset,
   // Processor-side requests
   input  logic               memRead,
   input  logic               memWrite,
   input  ks10Pkg::addrT      memAddr,
   input  ks10Pkg::wordT      memWriteData,
   // Configuration writes
   input  logic               cfgWrite,
   input  ssramPkg::unitsT    cfgUnits,
   input  logic               cfgProtect,
   // Processor-side responses
   output ks10Pkg::wordT      memReadData,
   output logic               memAck,
   output logic               memNxm,
   output logic               memProt,
   output logic               memBusy,
   // SSRAM device pins
   output ssramPkg::ssramAddrT ssramAddr,
   inout  ks10Pkg::wordT      ssramData,
   output logic               ssramWr
  );

   // Configuration seen by the controller
   ssramPkg::unitsT memUnits;
   logic            writeProtect;

   //
   // Size and write-protect registers
   //

   memConfig
     #(
       .defaultUnits (defaultUnits)
      )
   i_memConfig
     (
      .clk          (clk),
      .reset        (reset),
      .cfgWrite     (cfgWrite),
      .cfgUnits     (cfgUnits),
      .cfgProtect   (cfgProtect),
      .memUnits     (memUnits),
      .writeProtect (writeProtect)
     );

   //
   // Request sequencer and SSRAM pin drivers
   //

   memCtrl i_memCtrl
     (
      .clk          (clk),
      .reset        (reset),
      .memRead      (memRead),
      .memWrite     (memWrite),
      .memAddr      (memAddr),
      .memWriteData (memWriteData),
      .memUnits     (memUnits),
      .writeProtect (writeProtect),
      .memReadData  (memReadData),
      .memAck       (memAck),
      .memNxm       (memNxm),
      .memProt      (memProt),
      .memBusy      (memBusy),
      .ssramAddr    (ssramAddr),
      .ssramData    (ssramData),
      .ssramWr      (ssramWr)
     );

endmodule

//--- ssramModel.sv
`timescale 1ns/10ps

// Behavioral flow-through synchronous SRAM
// Single cycles only, so no burst advance and no separate clock
// Address and write enable are latched on the falling clock edge

module ssramModel
  #(
    // Words fitted on the board
    parameter int depth = 131072
   )
  (
   input  logic                clk,
   input  ssramPkg::ssramAddrT ssramAddr,
   inout  ks10Pkg::wordT       ssramData,
   input  logic                ssramWr
  );

   // Storage array
   ks10Pkg::wordT mem [0:depth-1];

   // Address taken at the last falling edge
   int latchedAddr;

   // Zero fill at power up
   initial
   begin
      for (int i = 0; i < depth; i++)
      begin
         mem[i] = '0;
      end
      latchedAddr = 0;
   end

   //
   // Falling edge address latch and write
   // Upper address pins are unused on this part
   //

   always @(negedge clk)
   begin
      latchedAddr <= int'(ssramAddr % depth);
      if (ssramWr)
      begin
         mem[ssramAddr % depth] <= ssramData;
      end
   end

   // Flow-through read, bus released while writing
   assign ssramData = ssramWr ? 'z : mem[latchedAddr];

endmodule

//--- testbench.sv
`timescale 1ns/10ps

// Random-stimulus testbench for the KS10 memory path
// Reference model tracks written words, size and write protect

module testbench;

   localparam int clkPeriod   = 8;
   localparam int resetCycles = 3;
   localparam int numSteps    = 2000;

   // Each step takes at most three cycles
   localparam int timeoutNs = (numSteps * 10 + resetCycles + 20) * clkPeriod;

   // DUT inputs
   logic            clk;
   logic            reset;
   logic            memRead;
   logic            memWrite;
   ks10Pkg::addrT   memAddr;
   ks10Pkg::wordT   memWriteData;
   logic            cfgWrite;
   ssramPkg::unitsT cfgUnits;
   logic            cfgProtect;

   // DUT outputs
   ks10Pkg::wordT       memReadData;
   logic                memAck;
   logic                memNxm;
   logic                memProt;
   logic                memBusy;
   ssramPkg::ssramAddrT ssramAddr;
   wire ks10Pkg::wordT  ssramData;
   logic                ssramWr;

   // Reference model state
   ks10Pkg::wordT   refMem [ks10Pkg::addrT];
   ssramPkg::unitsT refUnits;
   logic            refProtect;
   // memReadData holds until the next read ack
   ks10Pkg::wordT   lastRead;

   integer seed;

   ks10Mem
     #(
       .defaultUnits (1)
      )
   i_dut
     (
      .clk          (clk),
      .reset        (reset),
      .memRead      (memRead),
      .memWrite     (memWrite),
      .memAddr      (memAddr),
      .memWriteData (memWriteData),
      .cfgWrite     (cfgWrite),
      .cfgUnits     (cfgUnits),
      .cfgProtect   (cfgProtect),
      .memReadData  (memReadData),
      .memAck       (memAck),
      .memNxm       (memNxm),
      .memProt      (memProt),
      .memBusy      (memBusy),
      .ssramAddr    (ssramAddr),
      .ssramData    (ssramData),
      .ssramWr      (ssramWr)
     );

   // SSRAM of 128K words or four units
   ssramModel
     #(
       .depth (131072)
      )
   i_ssram
     (
      .clk       (clk),
      .ssramAddr (ssramAddr),
      .ssramData (ssramData),
      .ssramWr   (ssramWr)
     );

   always #(clkPeriod / 2) clk = ~clk;

   // Hang detector
   initial
   begin
      #(timeoutNs);
      $display("Watchdog expired at %0t, the run hung", $time);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog timeout");
   end

   // Uniform value in 0 to n-1
   function automatic int randBelow(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // Random 36-bit word
   function automatic ks10Pkg::wordT randWord();
      logic [63:0] wide;
      wide = {$random(seed), $random(seed)};
      return wide[35:0];
   endfunction

   // Address over 8 units
   // Mostly a few low offsets so reads hit earlier writes
   function automatic ks10Pkg::addrT randAddr();
      int unit;
      int offset;
      unit = randBelow(8);
      if (randBelow(4) == 0)
      begin
         offset = randBelow(32768);
      end
      else
      begin
         offset = randBelow(8);
      end
      return ks10Pkg::addrT'((unit << ssramPkg::unitShift) + offset);
   endfunction

   task automatic checkWord(input ks10Pkg::wordT actual, input ks10Pkg::wordT expected,
                            input string what);
      if (actual !== expected)
      begin
         $display("Mismatch at %0t: %s, got %h expected %h", $time, what, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "word compare failed");
      end
   endtask

   task automatic checkAddr(input ssramPkg::ssramAddrT actual,
                            input ssramPkg::ssramAddrT expected, input string what);
      if (actual !== expected)
      begin
         $display("Mismatch at %0t: %s, got %h expected %h", $time, what, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "address compare failed");
      end
   endtask

   task automatic checkFlag(input logic actual, input logic expected, input string what);
      if (actual !== expected)
      begin
         $display("Mismatch at %0t: %s, got %b expected %b", $time, what, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "flag compare failed");
      end
   endtask

   // All response pulses and levels in one go
   task automatic checkResponses(input logic expAck, input logic expNxm, input logic expProt,
                                 input logic expBusy, input logic expWr, input string when);
      checkFlag(memAck, expAck, {"memAck in ", when});
      checkFlag(memNxm, expNxm, {"memNxm in ", when});
      checkFlag(memProt, expProt, {"memProt in ", when});
      checkFlag(memBusy, expBusy, {"memBusy in ", when});
      checkFlag(ssramWr, expWr, {"ssramWr in ", when});
   endtask

   task automatic idleCycle();
      @(negedge clk);
      checkResponses(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "idle cycle");
   endtask

   // New size and protect apply to strobes from the next edge on
   task automatic writeConfig(input ssramPkg::unitsT units, input logic protect);
      cfgWrite   = 1'b1;
      cfgUnits   = units;
      cfgProtect = protect;
      @(negedge clk);
      cfgWrite = 1'b0;
      // Sizes above 32 units are clamped
      refUnits   = (units > 6'd32) ? 6'd32 : units;
      refProtect = protect;
      checkResponses(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "config cycle");
   endtask

   // One strobe, with an optional stray strobe while busy
   task automatic runAccess(input logic isWrite, input ks10Pkg::addrT addr,
                            input ks10Pkg::wordT data, input logic busyStrobe);
      logic          inRange;
      logic          expNxm;
      logic          expProt;
      ks10Pkg::wordT expData;
      inRange = (addr >> ssramPkg::unitShift) < refUnits;
      expNxm  = ~inRange;
      expProt = inRange & isWrite & refProtect;

      memRead      = ~isWrite;
      memWrite     = isWrite;
      memAddr      = addr;
      memWriteData = data;
      @(negedge clk);
      memRead  = 1'b0;
      memWrite = 1'b0;

      if (expNxm | expProt)
      begin
         // Fault answered at once without an SSRAM cycle
         checkResponses(1'b0, expNxm, expProt, 1'b0, 1'b0, "fault cycle");
         checkWord(memReadData, lastRead, "read data held after fault");
      end
      else
      begin
         checkResponses(1'b0, 1'b0, 1'b0, 1'b1, isWrite, "access cycle");
         // Processor address in the low pins, upper pins zero
         checkAddr(ssramAddr, {3'b000, addr}, "SSRAM address");
         if (isWrite)
         begin
            checkWord(ssramData, data, "SSRAM write data");
         end
         if (busyStrobe)
         begin
            // Must be dropped by the controller
            memWrite     = randBelow(2);
            memRead      = ~memWrite;
            memAddr      = randAddr();
            memWriteData = randWord();
         end
         @(negedge clk);
         memRead  = 1'b0;
         memWrite = 1'b0;
         checkResponses(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, "acknowledge cycle");
         if (isWrite)
         begin
            refMem[addr] = data;
            checkWord(memReadData, lastRead, "read data held after write");
         end
         else
         begin
            // Unwritten words read as zero fill
            expData  = refMem.exists(addr) ? refMem[addr] : '0;
            lastRead = expData;
            checkWord(memReadData, expData, "read data");
         end
      end
   endtask

   initial
   begin
      int choice;
      seed         = 32'hfa7cb8c5;
      clk          = 1'b0;
      reset        = 1'b1;
      memRead      = 1'b0;
      memWrite     = 1'b0;
      memAddr      = '0;
      memWriteData = '0;
      cfgWrite     = 1'b0;
      cfgUnits     = '0;
      cfgProtect   = 1'b0;
      refUnits     = 6'd1;
      refProtect   = 1'b0;
      lastRead     = '0;

      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      checkResponses(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "cycle after reset");
      checkWord(memReadData, '0, "read data after reset");

      // Address 0 reads zero with the default size of one unit
      runAccess(1'b0, '0, '0, 1'b0);

      for (int step = 0; step < numSteps; step++)
      begin
         choice = randBelow(16);
         if (choice == 0)
         begin
            // Protect on now and then
            // Size 0 makes all accesses NXM
            writeConfig(randBelow(5), randBelow(4) == 0);
         end
         else if (choice < 3)
         begin
            idleCycle();
         end
         else
         begin
            runAccess(randBelow(2), randAddr(), randWord(), randBelow(4) == 0);
         end
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- src.f
ks10Pkg.sv
ssramPkg.sv
memConfig.sv
memCtrl.sv
ks10Mem.sv
ssramModel.sv
testbench.sv

//--- Bender.yml
package:
  name: ks10mem

sources:
  - ks10Pkg.sv
  - ssramPkg.sv
  - memConfig.sv
  - memCtrl.sv
  - ks10Mem.sv
  - target: simulation
    files:
      - ssramModel.sv
      - testbench.sv
